//--- project.f
bp_lite_pkg.sv
bp_lite_to_axi_lite_master.sv
axi_lite_regfile.sv
io_axi_lite_top.sv
tb_io_axi_lite_top.sv

//--- Bender.yml
package:
  name: io_axi_lite

sources:
  - bp_lite_pkg.sv
  - bp_lite_to_axi_lite_master.sv
  - axi_lite_regfile.sv
  - io_axi_lite_top.sv
  - target: test
    files:
      - tb_io_axi_lite_top.sv

//--- tb_io_axi_lite_top.sv
`timescale 1ns/1ns

module tb_io_axi_lite_top
  import bp_lite_pkg::*;
();

  localparam int num_entries_lp     = 15;
  localparam int clk_period_lp      = 20;
  localparam int watchdog_cycles_lp = num_entries_lp * 200 + 10;

  logic                          aclk;
  logic                          aresetn;
  io_msg_type_e                  io_cmd_type;
  logic [io_addr_width_lp-1:0]   io_cmd_addr;
  io_msg_size_e                  io_cmd_size;
  logic [axi_data_width_lp-1:0]  io_cmd_data;
  logic                          io_cmd_v;
  logic                          io_cmd_ready;
  io_msg_type_e                  io_resp_type;
  logic [io_addr_width_lp-1:0]   io_resp_addr;
  io_msg_size_e                  io_resp_size;
  logic [axi_data_width_lp-1:0]  io_resp_data;
  logic                          io_resp_v;
  logic                          io_resp_yumi;

  // Command table with the expected response data
  io_msg_type_e                  tbl_type [num_entries_lp];
  logic [io_addr_width_lp-1:0]   tbl_addr [num_entries_lp];
  io_msg_size_e                  tbl_size [num_entries_lp];
  logic [axi_data_width_lp-1:0]  tbl_data [num_entries_lp];
  logic [axi_data_width_lp-1:0]  tbl_exp  [num_entries_lp];

  io_axi_lite_top dut0 (
    .aclk_i         (aclk),
    .aresetn_i      (aresetn),
    .io_cmd_type_i  (io_cmd_type),
    .io_cmd_addr_i  (io_cmd_addr),
    .io_cmd_size_i  (io_cmd_size),
    .io_cmd_data_i  (io_cmd_data),
    .io_cmd_v_i     (io_cmd_v),
    .io_cmd_ready_o (io_cmd_ready),
    .io_resp_type_o (io_resp_type),
    .io_resp_addr_o (io_resp_addr),
    .io_resp_size_o (io_resp_size),
    .io_resp_data_o (io_resp_data),
    .io_resp_v_o    (io_resp_v),
    .io_resp_yumi_i (io_resp_yumi)
  );

  always #(clk_period_lp / 2) aclk = ~aclk;

  task automatic compare(input logic [63:0] actual, input logic [63:0] expected,
                         input string msg);
    if (actual !== expected) begin
      $display("ERR %0t: %s, got %h, expected %h", $time, msg, actual, expected);
      $display("test failed");
      $fatal(1);
    end
  endtask

  task automatic set_entry(input int idx, input io_msg_type_e t,
                           input logic [io_addr_width_lp-1:0] a, input io_msg_size_e s,
                           input logic [axi_data_width_lp-1:0] d,
                           input logic [axi_data_width_lp-1:0] e);
    tbl_type[idx] = t;
    tbl_addr[idx] = a;
    tbl_size[idx] = s;
    tbl_data[idx] = d;
    tbl_exp[idx]  = e;
  endtask

  // Narrow writes carry junk in the unused lanes to catch bad strobes
  task automatic fill_table();
    set_entry(0,  e_io_uc_rd, 32'h0000_0008, e_io_size_8, 64'h0, 64'h0);
    set_entry(1,  e_io_uc_rd, 32'h0000_0078, e_io_size_8, 64'h0, 64'h0);
    set_entry(2,  e_io_uc_wr, 32'h0000_0000, e_io_size_8, 64'h1122_3344_5566_7788, 64'h0);
    set_entry(3,  e_io_uc_rd, 32'h0000_0000, e_io_size_8, 64'h0, 64'h1122_3344_5566_7788);
    set_entry(4,  e_io_uc_wr, 32'h0000_0000, e_io_size_1, 64'hFFFF_FFFF_FFFF_FFAA, 64'h0);
    set_entry(5,  e_io_uc_wr, 32'h0000_0002, e_io_size_2, 64'h9999_9999_BBCC_9999, 64'h0);
    set_entry(6,  e_io_uc_rd, 32'h0000_0000, e_io_size_8, 64'h0, 64'h1122_3344_BBCC_77AA);
    set_entry(7,  e_io_uc_wr, 32'h0000_0004, e_io_size_4, 64'hDDEE_FF99_1234_5678, 64'h0);
    set_entry(8,  e_io_uc_wr, 32'h0000_0007, e_io_size_1, 64'h5A77_7777_7777_7777, 64'h0);
    set_entry(9,  e_io_uc_rd, 32'h0000_0000, e_io_size_8, 64'h0, 64'h5AEE_FF99_BBCC_77AA);
    // Out of range, these alias onto words 0 and 1 if decoding is wrong
    set_entry(10, e_io_uc_wr, 32'h0000_0080, e_io_size_8, 64'hDEAD_BEEF_CAFE_F00D, 64'h0);
    set_entry(11, e_io_uc_wr, 32'h1000_0008, e_io_size_8, 64'h0123_4567_89AB_CDEF, 64'h0);
    set_entry(12, e_io_uc_rd, 32'h0000_0080, e_io_size_8, 64'h0, 64'h0);
    set_entry(13, e_io_uc_rd, 32'h0000_0000, e_io_size_8, 64'h0, 64'h5AEE_FF99_BBCC_77AA);
    set_entry(14, e_io_uc_rd, 32'h0000_0008, e_io_size_8, 64'h0, 64'h0);
  endtask

  // Response must echo the header and carry the expected data
  task automatic check_response(input int idx);
    compare(io_resp_v, 1'b1, $sformatf("entry %0d resp valid", idx));
    compare(io_resp_type, tbl_type[idx], $sformatf("entry %0d resp type", idx));
    compare(io_resp_addr, tbl_addr[idx], $sformatf("entry %0d resp addr", idx));
    compare(io_resp_size, tbl_size[idx], $sformatf("entry %0d resp size", idx));
    compare(io_resp_data, tbl_exp[idx], $sformatf("entry %0d resp data", idx));
  endtask

  // Called and returns on a falling edge
  task automatic run_entry(input int idx);
    int unsigned hold;
    io_cmd_type = tbl_type[idx];
    io_cmd_addr = tbl_addr[idx];
    io_cmd_size = tbl_size[idx];
    io_cmd_data = tbl_data[idx];
    io_cmd_v    = 1'b1;
    while (!io_cmd_ready) begin
      @(negedge aclk);
    end
    @(negedge aclk);
    io_cmd_v = 1'b0;
    // Bus traffic in flight
    while (!io_resp_v) begin
      compare(io_cmd_ready, 1'b0, $sformatf("entry %0d cmd ready while busy", idx));
      @(negedge aclk);
    end
    hold = $urandom % 4;
    repeat (hold) begin
      check_response(idx);
      compare(io_cmd_ready, 1'b0, $sformatf("entry %0d cmd ready while held", idx));
      @(negedge aclk);
    end
    check_response(idx);
    io_resp_yumi = 1'b1;
    @(negedge aclk);
    io_resp_yumi = 1'b0;
    compare(io_resp_v, 1'b0, $sformatf("entry %0d resp valid after yumi", idx));
    compare(io_cmd_ready, 1'b1, $sformatf("entry %0d cmd ready after yumi", idx));
  endtask

  initial begin
    void'($urandom(80));
    aclk         = 1'b0;
    aresetn      = 1'b0;
    io_cmd_type  = e_io_uc_rd;
    io_cmd_addr  = '0;
    io_cmd_size  = e_io_size_1;
    io_cmd_data  = '0;
    io_cmd_v     = 1'b0;
    io_resp_yumi = 1'b0;
    fill_table();
    repeat (5) @(negedge aclk);
    aresetn = 1'b1;
    @(negedge aclk);
    compare(io_cmd_ready, 1'b1, "cmd ready after reset");
    compare(io_resp_v, 1'b0, "resp valid after reset");
    for (int i = 0; i < num_entries_lp; i++) begin
      run_entry(i);
    end
    $display("test passed");
    $finish;
  end

  // Watchdog
  initial begin
    repeat (watchdog_cycles_lp) @(posedge aclk);
    $display("timeout: response never arrived");
    $display("test failed");
    $fatal(1);
  end

endmodule

//--- io_axi_lite_top.sv
`timescale 1ns/1ns

module io_axi_lite_top
  import bp_lite_pkg::*;
(
  input  logic                          aclk_i,
  input  logic                          aresetn_i,

  // Command port
  input  io_msg_type_e                  io_cmd_type_i,
  input  logic [io_addr_width_lp-1:0]   io_cmd_addr_i,
  input  io_msg_size_e                  io_cmd_size_i,
  input  logic [axi_data_width_lp-1:0]  io_cmd_data_i,
  input  logic                          io_cmd_v_i,
  output logic                          io_cmd_ready_o,

  // Response port
  output io_msg_type_e                  io_resp_type_o,
  output logic [io_addr_width_lp-1:0]   io_resp_addr_o,
  output io_msg_size_e                  io_resp_size_o,
  output logic [axi_data_width_lp-1:0]  io_resp_data_o,
  output logic                          io_resp_v_o,
  input  logic                          io_resp_yumi_i
);

  // AXI4-Lite channels between bridge and register file
  logic [io_addr_width_lp-1:0]   awaddr;
  logic [2:0]                    awprot;
  logic                          awvalid;
  logic                          awready;
  logic [axi_data_width_lp-1:0]  wdata;
  logic [axi_strb_width_lp-1:0]  wstrb;
  logic                          wvalid;
  logic                          wready;
  logic [1:0]                    bresp;
  logic                          bvalid;
  logic                          bready;
  logic [io_addr_width_lp-1:0]   araddr;
  logic [2:0]                    arprot;
  logic                          arvalid;
  logic                          arready;
  logic [axi_data_width_lp-1:0]  rdata;
  logic [1:0]                    rresp;
  logic                          rvalid;
  logic                          rready;

  bp_lite_to_axi_lite_master u_bridge (
    .aclk_i               (aclk_i),
    .aresetn_i            (aresetn_i),
    .io_cmd_type_i        (io_cmd_type_i),
    .io_cmd_addr_i        (io_cmd_addr_i),
    .io_cmd_size_i        (io_cmd_size_i),
    .io_cmd_data_i        (io_cmd_data_i),
    .io_cmd_v_i           (io_cmd_v_i),
    .io_cmd_ready_o       (io_cmd_ready_o),
    .io_resp_type_o       (io_resp_type_o),
    .io_resp_addr_o       (io_resp_addr_o),
    .io_resp_size_o       (io_resp_size_o),
    .io_resp_data_o       (io_resp_data_o),
    .io_resp_v_o          (io_resp_v_o),
    .io_resp_yumi_i       (io_resp_yumi_i),
    .m_axi_lite_awaddr_o  (awaddr),
    .m_axi_lite_awprot_o  (awprot),
    .m_axi_lite_awvalid_o (awvalid),
    .m_axi_lite_awready_i (awready),
    .m_axi_lite_wdata_o   (wdata),
    .m_axi_lite_wstrb_o   (wstrb),
    .m_axi_lite_wvalid_o  (wvalid),
    .m_axi_lite_wready_i  (wready),
    .m_axi_lite_bresp_i   (bresp),
    .m_axi_lite_bvalid_i  (bvalid),
    .m_axi_lite_bready_o  (bready),
    .m_axi_lite_araddr_o  (araddr),
    .m_axi_lite_arprot_o  (arprot),
    .m_axi_lite_arvalid_o (arvalid),
    .m_axi_lite_arready_i (arready),
    .m_axi_lite_rdata_i   (rdata),
    .m_axi_lite_rresp_i   (rresp),
    .m_axi_lite_rvalid_i  (rvalid),
    .m_axi_lite_rready_o  (rready)
  );

  axi_lite_regfile u_regfile (
    .aclk_i               (aclk_i),
    .aresetn_i            (aresetn_i),
    .s_axi_lite_awaddr_i  (awaddr),
    .s_axi_lite_awprot_i  (awprot),
    .s_axi_lite_awvalid_i (awvalid),
    .s_axi_lite_awready_o (awready),
    .s_axi_lite_wdata_i   (wdata),
    .s_axi_lite_wstrb_i   (wstrb),
    .s_axi_lite_wvalid_i  (wvalid),
    .s_axi_lite_wready_o  (wready),
    .s_axi_lite_bresp_o   (bresp),
    .s_axi_lite_bvalid_o  (bvalid),
    .s_axi_lite_bready_i  (bready),
    .s_axi_lite_araddr_i  (araddr),
    .s_axi_lite_arprot_i  (arprot),
    .s_axi_lite_arvalid_i (arvalid),
    .s_axi_lite_arready_o (arready),
    .s_axi_lite_rdata_o   (rdata),
    .s_axi_lite_rresp_o   (rresp),
    .s_axi_lite_rvalid_o  (rvalid),
    .s_axi_lite_rready_i  (rready)
  );

endmodule

//--- axi_lite_regfile.sv
`timescale 1ns/1ns

module axi_lite_regfile
  import bp_lite_pkg::*;
(
  input  logic                          aclk_i,
  input  logic                          aresetn_i,

  // Write address channel
  input  logic [io_addr_width_lp-1:0]   s_axi_lite_awaddr_i,
  input  logic [2:0]                    s_axi_lite_awprot_i,
  input  logic                          s_axi_lite_awvalid_i,
  output logic                          s_axi_lite_awready_o,

  // Write data channel
  input  logic [axi_data_width_lp-1:0]  s_axi_lite_wdata_i,
  input  logic [axi_strb_width_lp-1:0]  s_axi_lite_wstrb_i,
  input  logic                          s_axi_lite_wvalid_i,
  output logic                          s_axi_lite_wready_o,

  // Write response channel
  output logic [1:0]                    s_axi_lite_bresp_o,
  output logic                          s_axi_lite_bvalid_o,
  input  logic                          s_axi_lite_bready_i,

  // Read address channel
  input  logic [io_addr_width_lp-1:0]   s_axi_lite_araddr_i,
  input  logic [2:0]                    s_axi_lite_arprot_i,
  input  logic                          s_axi_lite_arvalid_i,
  output logic                          s_axi_lite_arready_o,

  // Read data channel
  output logic [axi_data_width_lp-1:0]  s_axi_lite_rdata_o,
  output logic [1:0]                    s_axi_lite_rresp_o,
  output logic                          s_axi_lite_rvalid_o,
  input  logic                          s_axi_lite_rready_i
);

  typedef enum logic [1:0] {
    e_s_idle,
    e_s_bresp,
    e_s_rresp
  } state_e;

  state_e state_r;

  logic [axi_data_width_lp-1:0]     regs_r [regfile_words_lp];
  logic [axi_data_width_lp-1:0]     rdata_r;
  logic [1:0]                       bresp_r;
  logic [1:0]                       rresp_r;

  logic                             idle;
  logic                             wr_pair;
  logic                             wr_fire;
  logic                             rd_fire;
  logic                             wr_ok;
  logic                             rd_ok;
  logic [regfile_idx_width_lp-1:0]  wr_idx;
  logic [regfile_idx_width_lp-1:0]  rd_idx;

  assign idle    = (state_r == e_s_idle);
  assign wr_pair = s_axi_lite_awvalid_i & s_axi_lite_wvalid_i;

  // Write wins over a read offered in the same cycle
  assign wr_fire = idle & wr_pair;
  assign rd_fire = idle & ~wr_pair & s_axi_lite_arvalid_i;

  assign s_axi_lite_awready_o = wr_fire;
  assign s_axi_lite_wready_o  = wr_fire;
  assign s_axi_lite_arready_o = idle & ~wr_pair;

  // Word index from bits 6:3, anything above that is out of range
  assign wr_idx = s_axi_lite_awaddr_i[regfile_idx_width_lp+2:3];
  assign rd_idx = s_axi_lite_araddr_i[regfile_idx_width_lp+2:3];

  // Non-zero protection is rejected like a bad address
  assign wr_ok = (s_axi_lite_awaddr_i[io_addr_width_lp-1:regfile_idx_width_lp+3] == '0)
               & (s_axi_lite_awprot_i == 3'b000);
  assign rd_ok = (s_axi_lite_araddr_i[io_addr_width_lp-1:regfile_idx_width_lp+3] == '0)
               & (s_axi_lite_arprot_i == 3'b000);

  // Register array, byte strobed
  always_ff @(posedge aclk_i) begin
    if (!aresetn_i) begin
      for (int i = 0; i < regfile_words_lp; i++) begin
        regs_r[i] <= '0;
      end
    end else if (wr_fire && wr_ok) begin
      for (int b = 0; b < axi_strb_width_lp; b++) begin
        if (s_axi_lite_wstrb_i[b]) begin
          regs_r[wr_idx][8*b +: 8] <= s_axi_lite_wdata_i[8*b +: 8];
        end
      end
    end
  end

  // Read data captured at AR
  always_ff @(posedge aclk_i) begin
    if (rd_fire) begin
      rdata_r <= rd_ok ? regs_r[rd_idx] : '0;
    end
  end

  always_ff @(posedge aclk_i) begin
    if (!aresetn_i) begin
      state_r <= e_s_idle;
      bresp_r <= axi_resp_okay_lp;
      rresp_r <= axi_resp_okay_lp;
    end else begin
      case (state_r)
        e_s_idle: begin
          if (wr_fire) begin
            state_r <= e_s_bresp;
            bresp_r <= wr_ok ? axi_resp_okay_lp : axi_resp_slverr_lp;
          end else if (rd_fire) begin
            state_r <= e_s_rresp;
            rresp_r <= rd_ok ? axi_resp_okay_lp : axi_resp_slverr_lp;
          end
        end
        e_s_bresp: begin
          if (s_axi_lite_bready_i) begin
            state_r <= e_s_idle;
          end
        end
        e_s_rresp: begin
          if (s_axi_lite_rready_i) begin
            state_r <= e_s_idle;
          end
        end
        default: state_r <= e_s_idle;
      endcase
    end
  end

  assign s_axi_lite_bvalid_o = (state_r == e_s_bresp);
  assign s_axi_lite_bresp_o  = bresp_r;
  assign s_axi_lite_rvalid_o = (state_r == e_s_rresp);
  assign s_axi_lite_rresp_o  = rresp_r;
  assign s_axi_lite_rdata_o  = rdata_r;

endmodule

//--- bp_lite_to_axi_lite_master.sv
`timescale 1ns/1ns

module bp_lite_to_axi_lite_master
  import bp_lite_pkg::*;
(
  input  logic                          aclk_i,
  input  logic                          aresetn_i,

  // I/O command port, valid/ready
  input  io_msg_type_e                  io_cmd_type_i,
  input  logic [io_addr_width_lp-1:0]   io_cmd_addr_i,
  input  io_msg_size_e                  io_cmd_size_i,
  input  logic [axi_data_width_lp-1:0]  io_cmd_data_i,
  input  logic                          io_cmd_v_i,
  output logic                          io_cmd_ready_o,

  // I/O response port, valid/yumi
  output io_msg_type_e                  io_resp_type_o,
  output logic [io_addr_width_lp-1:0]   io_resp_addr_o,
  output io_msg_size_e                  io_resp_size_o,
  output logic [axi_data_width_lp-1:0]  io_resp_data_o,
  output logic                          io_resp_v_o,
  input  logic                          io_resp_yumi_i,

  // Write address channel
  output logic [io_addr_width_lp-1:0]   m_axi_lite_awaddr_o,
  output logic [2:0]                    m_axi_lite_awprot_o,
  output logic                          m_axi_lite_awvalid_o,
  input  logic                          m_axi_lite_awready_i,

  // Write data channel
  output logic [axi_data_width_lp-1:0]  m_axi_lite_wdata_o,
  output logic [axi_strb_width_lp-1:0]  m_axi_lite_wstrb_o,
  output logic                          m_axi_lite_wvalid_o,
  input  logic                          m_axi_lite_wready_i,

  // Write response channel
  input  logic [1:0]                    m_axi_lite_bresp_i,
  input  logic                          m_axi_lite_bvalid_i,
  output logic                          m_axi_lite_bready_o,

  // Read address channel
  output logic [io_addr_width_lp-1:0]   m_axi_lite_araddr_o,
  output logic [2:0]                    m_axi_lite_arprot_o,
  output logic                          m_axi_lite_arvalid_o,
  input  logic                          m_axi_lite_arready_i,

  // Read data channel
  input  logic [axi_data_width_lp-1:0]  m_axi_lite_rdata_i,
  input  logic [1:0]                    m_axi_lite_rresp_i,
  input  logic                          m_axi_lite_rvalid_i,
  output logic                          m_axi_lite_rready_o
);

  typedef enum logic [2:0] {
    e_idle,
    e_write_req,
    e_write_resp,
    e_read_req,
    e_read_resp,
    e_resp_hold
  } state_e;

  state_e state_r, state_n;

  // Stored command
  io_msg_type_e                  type_r;
  logic [io_addr_width_lp-1:0]   addr_r;
  io_msg_size_e                  size_r;
  logic [axi_data_width_lp-1:0]  data_r;
  logic [axi_strb_width_lp-1:0]  strb_r;
  logic [axi_strb_width_lp-1:0]  size_mask;
  logic [axi_strb_width_lp-1:0]  strb_n;

  // Per-channel progress of a write
  logic aw_done_r;
  logic w_done_r;
  logic aw_hs;
  logic w_hs;
  logic ar_hs;
  logic aw_all;
  logic w_all;

  // Response capture
  logic                          cmd_accept;
  logic                          resp_beat;
  logic                          resp_ok;
  logic [axi_data_width_lp-1:0]  resp_data_r;

  assign cmd_accept = io_cmd_v_i & io_cmd_ready_o;

  // Byte lanes covered by the access, moved to the address offset
  always_comb begin
    case (io_cmd_size_i)
      e_io_size_1: size_mask = 8'h01;
      e_io_size_2: size_mask = 8'h03;
      e_io_size_4: size_mask = 8'h0F;
      default:     size_mask = 8'hFF;
    endcase
    strb_n = size_mask << io_cmd_addr_i[2:0];
  end

  always_ff @(posedge aclk_i) begin
    if (cmd_accept) begin
      type_r <= io_cmd_type_i;
      addr_r <= io_cmd_addr_i;
      size_r <= io_cmd_size_i;
      data_r <= io_cmd_data_i;
      strb_r <= strb_n;
    end
  end

  // AXI side handshakes
  assign m_axi_lite_awvalid_o = (state_r == e_write_req) & ~aw_done_r;
  assign m_axi_lite_wvalid_o  = (state_r == e_write_req) & ~w_done_r;
  assign m_axi_lite_arvalid_o = (state_r == e_read_req);
  assign m_axi_lite_bready_o  = (state_r == e_write_resp);
  assign m_axi_lite_rready_o  = (state_r == e_read_resp);

  assign aw_hs  = m_axi_lite_awvalid_o & m_axi_lite_awready_i;
  assign w_hs   = m_axi_lite_wvalid_o & m_axi_lite_wready_i;
  assign ar_hs  = m_axi_lite_arvalid_o & m_axi_lite_arready_i;
  assign aw_all = aw_done_r | aw_hs;
  assign w_all  = w_done_r | w_hs;

  // AW and W may complete in any order
  always_ff @(posedge aclk_i) begin
    if (!aresetn_i) begin
      aw_done_r <= 1'b0;
      w_done_r  <= 1'b0;
    end else if (cmd_accept) begin
      aw_done_r <= 1'b0;
      w_done_r  <= 1'b0;
    end else begin
      if (aw_hs) begin
        aw_done_r <= 1'b1;
      end
      if (w_hs) begin
        w_done_r <= 1'b1;
      end
    end
  end

  assign m_axi_lite_awaddr_o = addr_r;
  assign m_axi_lite_awprot_o = 3'b000;
  assign m_axi_lite_wdata_o  = data_r;
  assign m_axi_lite_wstrb_o  = strb_r;
  assign m_axi_lite_araddr_o = addr_r;
  assign m_axi_lite_arprot_o = 3'b000;

  // B or R beat ends the bus part of the command
  assign resp_beat = ((state_r == e_write_resp) & m_axi_lite_bvalid_i)
                   | ((state_r == e_read_resp) & m_axi_lite_rvalid_i);
  assign resp_ok   = (m_axi_lite_rresp_i == axi_resp_okay_lp);

  // Only a good read carries data back
  always_ff @(posedge aclk_i) begin
    if (resp_beat) begin
      resp_data_r <= ((state_r == e_read_resp) && resp_ok) ? m_axi_lite_rdata_i : '0;
    end
  end

  always_comb begin
    state_n = state_r;
    case (state_r)
      e_idle: begin
        if (cmd_accept) begin
          state_n = (io_cmd_type_i == e_io_uc_wr) ? e_write_req : e_read_req;
        end
      end
      e_write_req: begin
        if (aw_all && w_all) begin
          state_n = e_write_resp;
        end
      end
      e_write_resp: begin
        if (m_axi_lite_bvalid_i) begin
          state_n = e_resp_hold;
        end
      end
      e_read_req: begin
        if (ar_hs) begin
          state_n = e_read_resp;
        end
      end
      e_read_resp: begin
        if (m_axi_lite_rvalid_i) begin
          state_n = e_resp_hold;
        end
      end
      e_resp_hold: begin
        if (io_resp_yumi_i) begin
          state_n = e_idle;
        end
      end
      default: state_n = e_idle;
    endcase
  end

  always_ff @(posedge aclk_i) begin
    if (!aresetn_i) begin
      state_r <= e_idle;
    end else begin
      state_r <= state_n;
    end
  end

  // One command in flight
  assign io_cmd_ready_o = (state_r == e_idle);

  // Response echoes the stored header
  assign io_resp_v_o    = (state_r == e_resp_hold);
  assign io_resp_type_o = type_r;
  assign io_resp_addr_o = addr_r;
  assign io_resp_size_o = size_r;
  assign io_resp_data_o = resp_data_r;

endmodule

//--- bp_lite_pkg.sv
package bp_lite_pkg;

  // Uncached I/O command types
  typedef enum logic {
    e_io_uc_rd = 1'b0,
    e_io_uc_wr = 1'b1
  } io_msg_type_e;

  // Access size, encoded as log2 of the byte count
  typedef enum logic [1:0] {
    e_io_size_1 = 2'b00,
    e_io_size_2 = 2'b01,
    e_io_size_4 = 2'b10,
    e_io_size_8 = 2'b11
  } io_msg_size_e;

  // Command address width
  localparam int io_addr_width_lp = 32;

  // AXI4-Lite data path
  localparam int axi_data_width_lp = 64;
  localparam int axi_strb_width_lp = axi_data_width_lp / 8;

  // Register file geometry behind the bridge
  localparam int regfile_words_lp     = 16;
  localparam int regfile_idx_width_lp = $clog2(regfile_words_lp);

  // AXI response codes
  localparam logic [1:0] axi_resp_okay_lp   = 2'b00;
  localparam logic [1:0] axi_resp_slverr_lp = 2'b10;

endpackage
